//--- hdl/io_pkg.sv
package io_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [15:0] addr_t;
  typedef logic [63:0] dword_t;
  typedef logic [7:0]  lane_t;
  typedef logic [4:0]  tag_t;
  typedef logic [3:0]  core_id_t;

  // Bit 0 external, 1 timer, 2 DRAM receive, 3 incoming descriptor
  typedef logic [3:0]  irq_mask_t;

  ////////////////////////////////////////
  // Register map, address bits 6..0
  ////////////////////////////////////////

  // Write side
  localparam logic [6:0] OFS_DESC       = 7'h00;
  localparam logic [6:0] OFS_DRAM_ADDR  = 7'h08;
  localparam logic [6:0] OFS_TIMER_STEP = 7'h14;
  localparam logic [6:0] OFS_FLAGS_WR   = 7'h18;
  localparam logic [6:0] OFS_SEND       = 7'h38;
  localparam logic [6:0] OFS_TAKE       = 7'h39;
  localparam logic [6:0] OFS_FLAG_CLR   = 7'h3A;
  localparam logic [6:0] OFS_MASK       = 7'h3C;
  localparam logic [6:0] OFS_INT_ACK    = 7'h3D;

  // Read side
  localparam logic [6:0] OFS_RD_DESC     = 7'h40;
  localparam logic [6:0] OFS_RD_FLAGS    = 7'h48;
  localparam logic [6:0] OFS_RD_STATUS   = 7'h4C;
  localparam logic [6:0] OFS_RD_ID       = 7'h50;
  localparam logic [6:0] OFS_RD_TIMER_LO = 7'h54;
  localparam logic [6:0] OFS_RD_TIMER_HI = 7'h58;
  localparam logic [6:0] OFS_RD_INT      = 7'h5C;

  // Bus access sizes
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;

  // Reset values
  localparam word_t     TIMER_STEP_RST = 32'd1;
  localparam irq_mask_t MASK_RST       = 4'b0001;
  localparam int        ACK_TIMER_BIT  = 13;

  ////////////////////////////////////////
  // Bus and select bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic       valid;
    logic       wr;
    addr_t      addr;
    word_t      wdata;
    logic [1:0] size;
  } bus_cmd_t;

  typedef struct packed {
    lane_t  lanes;
    dword_t data;
    logic   strobe;
  } io_wr_t;

  typedef struct packed {
    logic desc;
    logic dram_addr;
    logic timer_step;
    logic flags_wr;
    logic send;
    logic take;
    logic flag_clr;
    logic mask_wr;
    logic int_ack;
  } io_wsel_t;

  typedef struct packed {
    logic desc;
    logic flags;
    logic status;
    logic id;
    logic timer_lo;
    logic timer_hi;
    logic int_flags;
  } io_rsel_t;

  // Byte-lane merge of replicated write data into a 64-bit value
  function automatic dword_t lane_merge(dword_t cur, dword_t data, lane_t lanes);
    dword_t res;
    res = cur;
    for (int i = 0; i < 8; i++) begin
      if (lanes[i]) begin
        res[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

//--- hdl/io_decode.sv
`timescale 1ns/1ps

module io_decode (
  input  logic             clk,
  input  logic             rst,
  input  io_pkg::bus_cmd_t bus,
  output io_pkg::io_wr_t   wr,
  output io_pkg::io_wsel_t wsel,
  output io_pkg::io_rsel_t rsel
);

  logic          io_win;
  logic          io_write;
  logic          io_read;
  logic [6:0]    ofs;
  io_pkg::lane_t base_lanes;

  // I/O window is bit 15 set, bit 14 clear
  assign io_win   = bus.valid && bus.addr[15] && !bus.addr[14];
  assign io_write = io_win && bus.wr;
  assign io_read  = io_win && !bus.wr;
  assign ofs      = bus.addr[6:0];

  always_comb begin
    case (bus.size)
      io_pkg::SIZE_BYTE: base_lanes = 8'h01;
      io_pkg::SIZE_HALF: base_lanes = 8'h03;
      default:           base_lanes = 8'h0F;
    endcase
  end

  // Lanes cover a 64-bit register, so the word half comes from address bit 2
  assign wr.lanes  = io_write ? (base_lanes << bus.addr[2:0]) : 8'h00;
  assign wr.data   = {bus.wdata, bus.wdata};
  assign wr.strobe = bus.wdata[0];

  ////////////////////////////////////////
  // Write selects
  ////////////////////////////////////////

  assign wsel.desc       = io_write && (ofs[6:3] == io_pkg::OFS_DESC[6:3]);
  assign wsel.dram_addr  = io_write && (ofs[6:3] == io_pkg::OFS_DRAM_ADDR[6:3]);
  assign wsel.timer_step = io_write && (ofs[6:2] == io_pkg::OFS_TIMER_STEP[6:2]);
  assign wsel.flags_wr   = io_write && (ofs[6:2] == io_pkg::OFS_FLAGS_WR[6:2]);
  assign wsel.send       = io_write && (ofs == io_pkg::OFS_SEND);
  assign wsel.take       = io_write && (ofs == io_pkg::OFS_TAKE);
  assign wsel.flag_clr   = io_write && (ofs == io_pkg::OFS_FLAG_CLR);
  assign wsel.mask_wr    = io_write && (ofs == io_pkg::OFS_MASK);
  assign wsel.int_ack    = io_write && (ofs == io_pkg::OFS_INT_ACK);

  ////////////////////////////////////////
  // Read selects
  ////////////////////////////////////////

  assign rsel.desc      = io_read && (ofs[6:3] == io_pkg::OFS_RD_DESC[6:3]);
  assign rsel.flags     = io_read && (ofs[6:2] == io_pkg::OFS_RD_FLAGS[6:2]);
  assign rsel.status    = io_read && (ofs[6:2] == io_pkg::OFS_RD_STATUS[6:2]);
  assign rsel.id        = io_read && (ofs[6:2] == io_pkg::OFS_RD_ID[6:2]);
  assign rsel.timer_lo  = io_read && (ofs[6:2] == io_pkg::OFS_RD_TIMER_LO[6:2]);
  assign rsel.timer_hi  = io_read && (ofs[6:2] == io_pkg::OFS_RD_TIMER_HI[6:2]);
  assign rsel.int_flags = io_read && (ofs[6:2] == io_pkg::OFS_RD_INT[6:2]);

  // At most one register is touched per command, read or write
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0({wsel, rsel})
  );

endmodule

//--- hdl/desc_out.sv
`timescale 1ns/1ps

module desc_out (
  input  logic             clk,
  input  logic             rst,
  input  io_pkg::io_wr_t   wr,
  input  io_pkg::io_wsel_t wsel,
  output io_pkg::dword_t   data_desc,
  output io_pkg::dword_t   dram_wr_addr,
  output logic             data_desc_valid,
  input  logic             data_desc_ready
);

  io_pkg::dword_t desc_q;
  io_pkg::dword_t addr_q;
  logic           valid_q;

  ////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////

  // Byte writable, software builds the value over several accesses
  always_ff @(posedge clk) begin
    if (wsel.desc) begin
      desc_q <= io_pkg::lane_merge(desc_q, wr.data, wr.lanes);
    end
    if (wsel.dram_addr) begin
      addr_q <= io_pkg::lane_merge(addr_q, wr.data, wr.lanes);
    end
  end

  ////////////////////////////////////////
  // Outgoing handshake
  ////////////////////////////////////////

  // Handshake clear wins over a send in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (valid_q && data_desc_ready) begin
      valid_q <= 1'b0;
    end else if (wsel.send && wr.strobe) begin
      valid_q <= 1'b1;
    end
  end

  assign data_desc       = desc_q;
  assign dram_wr_addr    = addr_q;
  assign data_desc_valid = valid_q;

  // Valid may only drop after the consumer took the descriptor
  a_valid_hold: assert property (
    @(posedge clk) disable iff (rst)
    data_desc_valid && !data_desc_ready |=> data_desc_valid
  );

endmodule

//--- hdl/int_timer.sv
`timescale 1ns/1ps

module int_timer (
  input  logic             clk,
  input  logic             rst,
  input  io_pkg::io_wr_t   wr,
  input  io_pkg::io_wsel_t wsel,
  output io_pkg::dword_t   timer,
  output logic             timer_irq
);

  io_pkg::dword_t timer_q;
  io_pkg::word_t  step_q;
  io_pkg::word_t  count_q;
  io_pkg::dword_t step_wr;
  logic           irq_q;

  // Free-running time base
  always_ff @(posedge clk) begin
    if (rst) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 64'd1;
    end
  end

  // Step sits in the upper word of its 64-bit slot
  assign step_wr = io_pkg::lane_merge({step_q, step_q}, wr.data, wr.lanes);

  always_ff @(posedge clk) begin
    if (rst) begin
      step_q <= io_pkg::TIMER_STEP_RST;
    end else if (wsel.timer_step) begin
      step_q <= step_wr[63:32];
    end
  end

  ////////////////////////////////////////
  // Interval interrupt
  ////////////////////////////////////////

  // A new step restarts the interval from zero
  always_ff @(posedge clk) begin
    if (rst || wsel.timer_step) begin
      count_q <= '0;
      irq_q   <= 1'b0;
    end else if (count_q == step_q) begin
      count_q <= '0;
      irq_q   <= 1'b1;
    end else begin
      count_q <= count_q + 32'd1;
      if (wsel.int_ack && wr.data[io_pkg::ACK_TIMER_BIT]) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign timer     = timer_q;
  assign timer_irq = irq_q;

endmodule

//--- hdl/dram_flags.sv
`timescale 1ns/1ps

module dram_flags (
  input  logic             clk,
  input  logic             rst,
  input  io_pkg::io_wr_t   wr,
  input  io_pkg::io_wsel_t wsel,
  input  io_pkg::tag_t     recv_tag,
  input  logic             recv_tag_valid,
  output io_pkg::word_t    flags
);

  io_pkg::tag_t   tag_q;
  logic           tag_valid_q;
  io_pkg::word_t  flags_q;
  io_pkg::word_t  flags_nxt;
  io_pkg::dword_t flags_wr;

  // Input stage for timing
  always_ff @(posedge clk) begin
    tag_q <= recv_tag;
    if (rst) begin
      tag_valid_q <= 1'b0;
    end else begin
      tag_valid_q <= recv_tag_valid;
    end
  end

  assign flags_wr = io_pkg::lane_merge({flags_q, flags_q}, wr.data, wr.lanes);

  // Later lines take priority, so an arriving tag beats a clear
  always_comb begin
    flags_nxt = flags_q;
    if (wsel.flags_wr) begin
      flags_nxt = flags_wr[31:0];
    end
    if (wsel.flag_clr) begin
      flags_nxt[wr.data[20:16]] = 1'b0;
    end
    if (tag_valid_q) begin
      flags_nxt[tag_q] = 1'b1;
    end
    // Tag 0 is not a real buffer
    flags_nxt[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_nxt;
    end
  end

  assign flags = flags_q;

  a_bit0_zero: assert property (@(posedge clk) disable iff (rst) !flags[0]);

endmodule

//--- hdl/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  io_pkg::io_wr_t    wr,
  input  io_pkg::io_wsel_t  wsel,
  input  logic              interrupt_in,
  input  logic              timer_raw,
  input  logic              flags_any,
  input  logic              in_desc_valid,
  output io_pkg::irq_mask_t mask,
  output logic              ext_irq,
  output logic              timer_irq
);

  io_pkg::irq_mask_t mask_q;

  // Mask byte sits in lane 4, enables are its upper nibble
  always_ff @(posedge clk) begin
    if (rst) begin
      mask_q <= io_pkg::MASK_RST;
    end else if (wsel.mask_wr && wr.lanes[4]) begin
      mask_q <= wr.data[7:4];
    end
  end

  ////////////////////////////////////////
  // Interrupt outputs
  ////////////////////////////////////////

  // External line shared by three sources
  assign ext_irq = (interrupt_in  && mask_q[0]) ||
                   (flags_any     && mask_q[2]) ||
                   (in_desc_valid && mask_q[3]);

  assign timer_irq = timer_raw && mask_q[1];

  assign mask = mask_q;

endmodule

//--- hdl/io_read_mux.sv
`timescale 1ns/1ps

module io_read_mux (
  input  logic              clk,
  input  logic              rst,
  input  io_pkg::io_rsel_t  rsel,
  input  logic              addr_bit2,
  input  io_pkg::dword_t    in_desc,
  input  logic              in_desc_valid,
  input  logic              data_desc_ready,
  input  io_pkg::word_t     flags,
  input  io_pkg::core_id_t  core_id,
  input  io_pkg::dword_t    timer,
  input  io_pkg::irq_mask_t mask,
  input  logic [3:0]        int_raw,
  output logic              rsp_valid,
  output io_pkg::word_t     rsp_data
);

  io_pkg::word_t rdata_q;
  logic          rvalid_q;

  // One response per read command, one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= |rsel;
    end
  end

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rsel.desc) begin
      rdata_q <= addr_bit2 ? in_desc[63:32] : in_desc[31:0];
    end else if (rsel.flags) begin
      rdata_q <= flags;
    end else if (rsel.status) begin
      rdata_q <= {23'd0, data_desc_ready, 7'd0, in_desc_valid};
    end else if (rsel.id) begin
      rdata_q <= {28'd0, core_id};
    end else if (rsel.timer_lo) begin
      rdata_q <= timer[31:0];
    end else if (rsel.timer_hi) begin
      rdata_q <= timer[63:32];
    end else if (rsel.int_flags) begin
      // Mask above the raw sources, same bit order in both nibbles
      rdata_q <= {24'd0, mask, int_raw};
    end
  end

  assign rsp_valid = rvalid_q;
  assign rsp_data  = rdata_q;

endmodule

//--- hdl/io_block.sv
`timescale 1ns/1ps

module io_block (
  input  logic             clk,
  input  logic             rst,
  input  io_pkg::bus_cmd_t bus,
  output logic             rsp_valid,
  output io_pkg::word_t    rsp_data,
  input  io_pkg::dword_t   in_desc,
  input  logic             in_desc_valid,
  output logic             in_desc_taken,
  input  io_pkg::tag_t     recv_tag,
  input  logic             recv_tag_valid,
  output io_pkg::dword_t   data_desc,
  output io_pkg::dword_t   dram_wr_addr,
  output logic             data_desc_valid,
  input  logic             data_desc_ready,
  input  io_pkg::core_id_t core_id,
  input  logic             interrupt_in,
  output logic             ext_irq,
  output logic             timer_irq
);

  io_pkg::io_wr_t    wr;
  io_pkg::io_wsel_t  wsel;
  io_pkg::io_rsel_t  rsel;
  io_pkg::dword_t    timer;
  io_pkg::word_t     flags;
  io_pkg::irq_mask_t mask;
  logic              timer_raw;
  logic              flags_any;
  logic [3:0]        int_raw;

  io_decode u_decode (
    .clk  (clk),
    .rst  (rst),
    .bus  (bus),
    .wr   (wr),
    .wsel (wsel),
    .rsel (rsel)
  );

  ////////////////////////////////////////
  // Write side peripherals
  ////////////////////////////////////////

  desc_out u_desc_out (
    .clk             (clk),
    .rst             (rst),
    .wr              (wr),
    .wsel            (wsel),
    .data_desc       (data_desc),
    .dram_wr_addr    (dram_wr_addr),
    .data_desc_valid (data_desc_valid),
    .data_desc_ready (data_desc_ready)
  );

  int_timer u_timer (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .wsel      (wsel),
    .timer     (timer),
    .timer_irq (timer_raw)
  );

  dram_flags u_flags (
    .clk            (clk),
    .rst            (rst),
    .wr             (wr),
    .wsel           (wsel),
    .recv_tag       (recv_tag),
    .recv_tag_valid (recv_tag_valid),
    .flags          (flags)
  );

  assign flags_any = |flags;

  irq_ctrl u_irq (
    .clk           (clk),
    .rst           (rst),
    .wr            (wr),
    .wsel          (wsel),
    .interrupt_in  (interrupt_in),
    .timer_raw     (timer_raw),
    .flags_any     (flags_any),
    .in_desc_valid (in_desc_valid),
    .mask          (mask),
    .ext_irq       (ext_irq),
    .timer_irq     (timer_irq)
  );

  // Take is a strobe, only wdata bit 0 matters
  assign in_desc_taken = wsel.take && wr.strobe;

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // Same bit order as the mask
  assign int_raw = {in_desc_valid, flags_any, timer_raw, interrupt_in};

  io_read_mux u_read_mux (
    .clk             (clk),
    .rst             (rst),
    .rsel            (rsel),
    .addr_bit2       (bus.addr[2]),
    .in_desc         (in_desc),
    .in_desc_valid   (in_desc_valid),
    .data_desc_ready (data_desc_ready),
    .flags           (flags),
    .core_id         (core_id),
    .timer           (timer),
    .mask            (mask),
    .int_raw         (int_raw),
    .rsp_valid       (rsp_valid),
    .rsp_data        (rsp_data)
  );

endmodule

//--- dv/io_block_tb.sv
`timescale 1ns/1ps

module io_block_tb;

  localparam int MAX_CASES = 128;

  // Window base with address bit 15 set and bit 14 clear
  localparam logic [8:0] WIN = 9'h100;

  logic              clk;
  logic              rst;
  io_pkg::bus_cmd_t  bus;
  logic              rsp_valid;
  io_pkg::word_t     rsp_data;
  io_pkg::dword_t    in_desc;
  logic              in_desc_valid;
  logic              in_desc_taken;
  io_pkg::tag_t      recv_tag;
  logic              recv_tag_valid;
  io_pkg::dword_t    data_desc;
  io_pkg::dword_t    dram_wr_addr;
  logic              data_desc_valid;
  logic              data_desc_ready;
  io_pkg::core_id_t  core_id;
  logic              interrupt_in;
  logic              ext_irq;
  logic              timer_irq;

  // Case table loaded from the data file
  string          op_a   [MAX_CASES];
  string          name_a [MAX_CASES];
  io_pkg::addr_t  addr_a [MAX_CASES];
  io_pkg::word_t  data_a [MAX_CASES];
  logic [1:0]     size_a [MAX_CASES];
  io_pkg::dword_t exp_a  [MAX_CASES];
  int             n_cases;
  int             cycles;
  int             cycle_limit;
  io_pkg::dword_t timer_prev;

  io_block UUT (
    .clk             (clk),
    .rst             (rst),
    .bus             (bus),
    .rsp_valid       (rsp_valid),
    .rsp_data        (rsp_data),
    .in_desc         (in_desc),
    .in_desc_valid   (in_desc_valid),
    .in_desc_taken   (in_desc_taken),
    .recv_tag        (recv_tag),
    .recv_tag_valid  (recv_tag_valid),
    .data_desc       (data_desc),
    .dram_wr_addr    (dram_wr_addr),
    .data_desc_valid (data_desc_valid),
    .data_desc_ready (data_desc_ready),
    .core_id         (core_id),
    .interrupt_in    (interrupt_in),
    .ext_irq         (ext_irq),
    .timer_irq       (timer_irq)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $fatal(1);
    end
  end

  ////////////////////////////////////////
  // Checks and bus helpers
  ////////////////////////////////////////

  task automatic compare_val(string name, io_pkg::dword_t exp, io_pkg::dword_t act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic require(logic cond, string what);
    assert (cond === 1'b1) else begin
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic set_bus(io_pkg::addr_t addr, logic wr, io_pkg::word_t wdata, logic [1:0] size);
    bus.valid = 1'b1;
    bus.wr    = wr;
    bus.addr  = addr;
    bus.wdata = wdata;
    bus.size  = size;
  endtask

  // One command cycle, from falling edge to falling edge
  task automatic drive_cmd(io_pkg::addr_t addr, logic wr, io_pkg::word_t wdata, logic [1:0] size);
    set_bus(addr, wr, wdata, size);
    @(negedge clk);
    bus = '0;
  endtask

  task automatic read_word(io_pkg::addr_t addr, string name, output io_pkg::word_t data);
    drive_cmd(addr, 1'b0, '0, 2'd2);
    require(rsp_valid, $sformatf("No read response in the cycle after read %s", name));
    data = rsp_data;
  endtask

  task automatic load_cases();
    int             fd;
    int             got;
    string          line;
    string          op;
    string          nm;
    io_pkg::addr_t  a;
    io_pkg::word_t  d;
    logic [1:0]     s;
    io_pkg::dword_t e;
    fd = $fopen("dv/io_cases.txt", "r");
    require(fd != 0, "Cannot open the case file dv/io_cases.txt");
    n_cases = 0;
    while (!$feof(fd)) begin
      got = $fgets(line, fd);
      // Skip comments and blank lines
      if (got > 0 && line.len() > 1 && line[0] != "#") begin
        got = $sscanf(line, "%s %h %h %h %h %s", op, a, d, s, e, nm);
        require(got == 6, $sformatf("Malformed case line: %s", line));
        require(n_cases < MAX_CASES, "Case file holds too many cases");
        op_a[n_cases]   = op;
        name_a[n_cases] = nm;
        addr_a[n_cases] = a;
        data_a[n_cases] = d;
        size_a[n_cases] = s;
        exp_a[n_cases]  = e;
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Case execution
  ////////////////////////////////////////

  task automatic run_case(int i);
    string          op;
    string          nm;
    io_pkg::word_t  rdata;
    io_pkg::word_t  lo;
    io_pkg::word_t  hi;
    io_pkg::dword_t now_val;
    op = op_a[i];
    nm = name_a[i];
    if (op == "wr") begin
      drive_cmd(addr_a[i], 1'b1, data_a[i], size_a[i]);
    end else if (op == "rd") begin
      read_word(addr_a[i], nm, rdata);
      compare_val(nm, exp_a[i], rdata);
      @(negedge clk);
      require(!rsp_valid, $sformatf("Read response of %s lasted more than one cycle", nm));
    end else if (op == "take") begin
      // Pulse is combinational, sampled in the command cycle
      set_bus(addr_a[i], 1'b1, data_a[i], size_a[i]);
      @(posedge clk);
      compare_val(nm, exp_a[i], in_desc_taken);
      @(negedge clk);
      bus = '0;
      @(posedge clk);
      compare_val({nm, "_end"}, 64'd0, in_desc_taken);
      @(negedge clk);
    end else if (op == "tag") begin
      recv_tag       = addr_a[i][4:0];
      recv_tag_valid = 1'b1;
      @(negedge clk);
      recv_tag_valid = 1'b0;
    end else if (op == "tagclr") begin
      // Clear lands on the edge where the registered tag is applied
      recv_tag       = addr_a[i][4:0];
      recv_tag_valid = 1'b1;
      @(negedge clk);
      recv_tag_valid = 1'b0;
      drive_cmd({WIN, io_pkg::OFS_FLAG_CLR}, 1'b1, data_a[i], 2'd2);
    end else if (op == "desc") begin
      compare_val(nm, exp_a[i], data_desc);
    end else if (op == "dram") begin
      compare_val(nm, exp_a[i], dram_wr_addr);
    end else if (op == "valid") begin
      compare_val(nm, exp_a[i], data_desc_valid);
    end else if (op == "ready") begin
      data_desc_ready = 1'b1;
      @(negedge clk);
      data_desc_ready = 1'b0;
    end else if (op == "idle") begin
      repeat (data_a[i]) @(negedge clk);
    end else if (op == "pin") begin
      interrupt_in = data_a[i][0];
      @(negedge clk);
    end else if (op == "ext") begin
      compare_val(nm, exp_a[i], ext_irq);
    end else if (op == "tirq") begin
      compare_val(nm, exp_a[i], timer_irq);
    end else if (op == "wirq") begin
      while (timer_irq !== 1'b1) @(negedge clk);
    end else if (op == "quiet") begin
      repeat (data_a[i]) begin
        @(negedge clk);
        compare_val(nm, 64'd0, timer_irq);
      end
    end else if (op == "tread") begin
      read_word({WIN, io_pkg::OFS_RD_TIMER_LO}, nm, lo);
      read_word({WIN, io_pkg::OFS_RD_TIMER_HI}, nm, hi);
      @(negedge clk);
      now_val = {hi, lo};
      require(now_val > timer_prev, $sformatf("Timer did not advance at %s", nm));
      // Nonzero expect gives the exact cycle distance to the previous read
      if (exp_a[i] != 0) begin
        compare_val(nm, exp_a[i], now_val - timer_prev);
      end
      timer_prev = now_val;
    end else begin
      require(1'b0, $sformatf("Unknown operation %s in case %s", op, nm));
    end
  endtask

  initial begin
    int            i;
    io_pkg::word_t max_step;
    clk             = 1'b0;
    rst             = 1'b1;
    bus             = '0;
    in_desc         = 64'hcafef00d_12345678;
    in_desc_valid   = 1'b1;
    recv_tag        = '0;
    recv_tag_valid  = 1'b0;
    data_desc_ready = 1'b0;
    core_id         = 4'h5;
    interrupt_in    = 1'b0;
    cycles          = 0;
    cycle_limit     = 0;
    timer_prev      = '0;
    load_cases();
    max_step = '0;
    for (i = 0; i < n_cases; i++) begin
      if (op_a[i] == "wr" && addr_a[i][6:2] == io_pkg::OFS_TIMER_STEP[6:2] &&
          data_a[i] > max_step) begin
        max_step = data_a[i];
      end
    end
    cycle_limit = 40 * n_cases + int'(max_step) + 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    require(!rsp_valid, "Read response valid right after reset");
    for (i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

//--- dv/io_cases.txt
# op addr data size expect name
# addr data size expect in hex, unused fields 0; tag ops carry the tag in addr
valid 0 0 0 0 valid_after_reset
wr 8000 11223344 2 0 desc_lo_word
wr 8004 aabbccdd 2 0 desc_hi_word
wr 8001 0000ee00 0 0 desc_byte1
wr 8006 55660000 1 0 desc_half3
wr 8008 00001000 2 0 dram_lo_word
wr 800c 00000002 2 0 dram_hi_word
wr 8038 00000000 0 0 send_no_strobe
valid 0 0 0 0 valid_no_strobe
wr 8038 00000001 0 0 send
desc 0 0 0 5566ccdd1122ee44 desc_merged
dram 0 0 0 0000000200001000 dram_merged
valid 0 0 0 1 valid_after_send
idle 0 4 0 0 hold_wait
valid 0 0 0 1 valid_held
desc 0 0 0 5566ccdd1122ee44 desc_held
ready 0 0 0 0 ready_pulse
valid 0 0 0 0 valid_dropped
rd 8050 0 2 5 read_core_id
rd 804c 0 2 1 read_status
rd 8040 0 2 12345678 read_in_desc_lo
rd 8044 0 2 cafef00d read_in_desc_hi
rd 805c 0 2 1a read_int_flags
take 8039 1 0 1 take_pulse
take 8039 0 0 0 take_no_strobe
tag 3 0 0 0 tag3
tag 7 0 0 0 tag7
tag 0 0 0 0 tag0
idle 0 2 0 0 tag_settle
rd 8048 0 2 88 flags_3_7
wr 803a 00030000 2 0 clear3
idle 0 2 0 0 clear3_settle
rd 8048 0 2 80 flags_after_clear3
wr 803a 00070000 2 0 clear7
idle 0 2 0 0 clear7_settle
rd 8048 0 2 0 flags_after_clear7
tagclr 7 00070000 0 0 tag_vs_clear
idle 0 2 0 0 race_settle
rd 8048 0 2 80 flags_tag_wins
wr 8018 0000f0f1 2 0 flags_overwrite
idle 0 2 0 0 overwrite_settle
rd 8048 0 2 f0f0 flags_word
wr 8019 0000ab00 0 0 flags_byte1
idle 0 2 0 0 byte_settle
rd 8048 0 2 abf0 flags_byte
wr 8014 00000032 2 0 step_50
wr 803c 00000030 0 0 mask_timer_ext
wirq 0 0 0 0 timer_fires
wr 803d 00002000 0 0 timer_ack
tirq 0 0 0 0 timer_acked
quiet 0 31 0 0 timer_quiet
wirq 0 0 0 0 timer_refires
tread 0 0 0 0 timer_first
idle 0 5 0 0 timer_gap
tread 0 0 0 8 timer_second
wr 803c 00000020 0 0 mask_timer_only
pin 0 1 0 0 irq_in_high
ext 0 0 0 0 ext_masked
wr 803c 00000030 0 0 mask_ext
ext 0 0 0 1 ext_follows_high
pin 0 0 0 0 irq_in_low
ext 0 0 0 0 ext_follows_low
wr 8018 00000000 2 0 flags_zero
wr 803c 00000070 0 0 mask_dram
ext 0 0 0 0 ext_no_flags
tag 9 0 0 0 tag9
idle 0 2 0 0 tag9_settle
ext 0 0 0 1 ext_dram_flag

//--- vlog.f
hdl/io_pkg.sv
hdl/io_decode.sv
hdl/desc_out.sv
hdl/int_timer.sv
hdl/dram_flags.sv
hdl/irq_ctrl.sv
hdl/io_read_mux.sv
hdl/io_block.sv
dv/io_block_tb.sv
